//--- vec_consts.svh
`ifndef VEC_CONSTS_SVH
`define VEC_CONSTS_SVH

// cells per vector
`define VEC_LEN 5

// bits per signed cell
`define VEC_CELL_W 8

// lanes computed per clock, VEC_LEN must be a multiple of this
`define VEC_TILING 1

`endif

//--- vec_pkg.sv
`default_nettype none

`include "vec_consts.svh"

package vec_pkg;

    // one signed cell
    typedef logic signed [`VEC_CELL_W-1:0] cell_t;

    // cell 0 sits in the low bits
    typedef logic [`VEC_LEN*`VEC_CELL_W-1:0] vec_t;

    // one tile of lanes
    typedef logic [`VEC_TILING*`VEC_CELL_W-1:0] tile_t;

    // lane index, must reach VEC_LEN
    typedef logic [$clog2(`VEC_LEN+1)-1:0] index_t;

    // 0 add, 1 subtract
    typedef logic [0:0] op_t;

    typedef enum logic [0:0] {
        SEQ_IDLE,
        SEQ_CALC
    } seq_state_t;

endpackage

`default_nettype wire

//--- operand_decode.sv
`timescale 1ns/100ps
`default_nettype none

module operand_decode (
    input  wire            clk,
    input  wire            rst,
    input  vec_pkg::vec_t  a,
    input  vec_pkg::op_t   a_op,
    input  wire            a_valid,
    output logic           a_ready,
    input  vec_pkg::vec_t  b,
    input  wire            b_valid,
    output logic           b_ready,
    input  wire            busy,
    input  wire            op_release,
    output vec_pkg::vec_t  opa,
    output vec_pkg::vec_t  opb,
    output vec_pkg::op_t   op,
    output logic           start
);

    logic a_held;
    logic b_held;
    logic a_take;
    logic b_take;

    assign a_ready = !a_held;
    assign b_ready = !b_held;

    assign a_take = a_valid && a_ready;
    assign b_take = b_valid && b_ready;

    // held flags, either operand may come first
    always_ff @(posedge clk) begin
        if (rst) begin
            a_held <= 1'b0;
            b_held <= 1'b0;
        end else if (op_release) begin
            a_held <= 1'b0;
            b_held <= 1'b0;
        end else begin
            if (a_take) begin
                a_held <= 1'b1;
            end
            if (b_take) begin
                b_held <= 1'b1;
            end
        end
    end

    // one pulse per pair, busy only rises the cycle after start
    always_ff @(posedge clk) begin
        if (rst) begin
            start <= 1'b0;
        end else begin
            start <= a_held && b_held && !busy && !start;
        end
    end

    // opcode travels with a
    always_ff @(posedge clk) begin
        if (a_take) begin
            opa <= a;
            op  <= a_op;
        end
        if (b_take) begin
            opb <= b;
        end
    end

    // execute must be idle whenever a new pair is issued
    a_start_not_busy: assert property (
        @(posedge clk) disable iff (rst)
        start |-> !busy
    ) else $error("start issued while execute busy");

    // operands stay put while the pair is being worked on
    a_operands_stable: assert property (
        @(posedge clk) disable iff (rst)
        (start || busy) && !op_release |=> $stable(opa) && $stable(opb) && $stable(op)
    ) else $error("operands changed before release");

endmodule

`default_nettype wire

//--- lane_execute.sv
`timescale 1ns/100ps
`default_nettype none

`include "vec_consts.svh"

module lane_execute (
    input  wire              clk,
    input  wire              rst,
    input  wire              start,
    input  wire              op_release,
    input  vec_pkg::vec_t    opa,
    input  vec_pkg::vec_t    opb,
    input  vec_pkg::op_t     op,
    output logic             busy,
    output vec_pkg::tile_t   lane_sums,
    output vec_pkg::index_t  lane_index,
    output logic             lane_err,
    output logic             lane_write,
    output logic             lane_last
);

    import vec_pkg::*;

    seq_state_t            state;
    logic [`VEC_TILING-1:0] tile_err;

    if ((`VEC_LEN % `VEC_TILING) != 0) begin : g_tiling_check
        $error("VEC_LEN must be a multiple of VEC_TILING");
    end

    // one signed adder or subtractor per lane of the tile
    for (genvar i = 0; i < `VEC_TILING; i++) begin : g_lane
        cell_t                      cell_a;
        cell_t                      cell_b;
        logic signed [`VEC_CELL_W:0] wide;

        assign cell_a = opa[(lane_index + i) * `VEC_CELL_W +: `VEC_CELL_W];
        assign cell_b = opb[(lane_index + i) * `VEC_CELL_W +: `VEC_CELL_W];

        // op 1 subtracts
        assign wide = op[0] ? cell_a - cell_b : cell_a + cell_b;

        assign lane_sums[i*`VEC_CELL_W +: `VEC_CELL_W] = wide[`VEC_CELL_W-1:0];

        // extra bit disagrees with result sign on overflow or underflow
        assign tile_err[i] = wide[`VEC_CELL_W] ^ wide[`VEC_CELL_W-1];
    end

    assign lane_err   = |tile_err;
    assign lane_write = (state == SEQ_CALC);
    assign lane_last  = lane_write &&
                        (lane_index == index_t'(`VEC_LEN - `VEC_TILING));

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= SEQ_IDLE;
            lane_index <= '0;
        end else begin
            case (state)
                SEQ_IDLE: begin
                    lane_index <= '0;
                    if (start) begin
                        state <= SEQ_CALC;
                    end
                end
                SEQ_CALC: begin
                    lane_index <= lane_index + index_t'(`VEC_TILING);
                    if (lane_last) begin
                        state <= SEQ_IDLE;
                    end
                end
                default: begin
                    state <= SEQ_IDLE;
                end
            endcase
        end
    end

    // held from start until the result leaves
    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
        end else if (start) begin
            busy <= 1'b1;
        end else if (op_release) begin
            busy <= 1'b0;
        end
    end

    a_index_in_range: assert property (
        @(posedge clk) disable iff (rst)
        lane_write |-> lane_index < index_t'(`VEC_LEN)
    ) else $error("lane index past end of vector");

endmodule

`default_nettype wire

//--- result_collect.sv
`timescale 1ns/100ps
`default_nettype none

`include "vec_consts.svh"

module result_collect (
    input  wire              clk,
    input  wire              rst,
    input  wire              start,
    input  vec_pkg::tile_t   lane_sums,
    input  vec_pkg::index_t  lane_index,
    input  wire              lane_err,
    input  wire              lane_write,
    input  wire              lane_last,
    output vec_pkg::vec_t    result,
    output logic             result_valid,
    input  wire              result_ready,
    output logic             error,
    output logic             op_release
);

    import vec_pkg::*;

    vec_t result_q;
    logic accept;

    assign accept     = result_valid && result_ready;
    assign op_release = accept;
    assign result     = result_q;

    // tile lands at its lane position
    always_ff @(posedge clk) begin
        if (lane_write) begin
            result_q[lane_index * `VEC_CELL_W +: `VEC_TILING * `VEC_CELL_W] <= lane_sums;
        end
    end

    // sticky over one vector
    always_ff @(posedge clk) begin
        if (rst) begin
            error <= 1'b0;
        end else if (start) begin
            error <= 1'b0;
        end else if (lane_write && lane_err) begin
            error <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            result_valid <= 1'b0;
        end else if (lane_write && lane_last) begin
            result_valid <= 1'b1;
        end else if (accept) begin
            result_valid <= 1'b0;
        end
    end

    // back-pressure holds the result
    a_result_hold: assert property (
        @(posedge clk) disable iff (rst)
        result_valid && !result_ready |=> result_valid && $stable(result) && $stable(error)
    ) else $error("result changed under back-pressure");

endmodule

`default_nettype wire

//--- vector_alu_top.sv
`timescale 1ns/100ps
`default_nettype none

module vector_alu_top (
    input  wire            clk,
    input  wire            rst,
    input  vec_pkg::vec_t  a,
    input  vec_pkg::op_t   a_op,
    input  wire            a_valid,
    output logic           a_ready,
    input  vec_pkg::vec_t  b,
    input  wire            b_valid,
    output logic           b_ready,
    output vec_pkg::vec_t  result,
    output logic           result_valid,
    input  wire            result_ready,
    output logic           error
);

    import vec_pkg::*;

    vec_t   opa;
    vec_t   opb;
    op_t    op;
    logic   start;
    logic   busy;
    logic   op_release;
    tile_t  lane_sums;
    index_t lane_index;
    logic   lane_err;
    logic   lane_write;
    logic   lane_last;

    operand_decode u_decode (
        .clk        (clk),
        .rst        (rst),
        .a          (a),
        .a_op       (a_op),
        .a_valid    (a_valid),
        .a_ready    (a_ready),
        .b          (b),
        .b_valid    (b_valid),
        .b_ready    (b_ready),
        .busy       (busy),
        .op_release (op_release),
        .opa        (opa),
        .opb        (opb),
        .op         (op),
        .start      (start)
    );

    lane_execute u_execute (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .op_release (op_release),
        .opa        (opa),
        .opb        (opb),
        .op         (op),
        .busy       (busy),
        .lane_sums  (lane_sums),
        .lane_index (lane_index),
        .lane_err   (lane_err),
        .lane_write (lane_write),
        .lane_last  (lane_last)
    );

    result_collect u_result (
        .clk          (clk),
        .rst          (rst),
        .start        (start),
        .lane_sums    (lane_sums),
        .lane_index   (lane_index),
        .lane_err     (lane_err),
        .lane_write   (lane_write),
        .lane_last    (lane_last),
        .result       (result),
        .result_valid (result_valid),
        .result_ready (result_ready),
        .error        (error),
        .op_release   (op_release)
    );

endmodule

`default_nettype wire

//--- tb_vector_alu.sv
`timescale 1ns/100ps
`default_nettype none

`include "vec_consts.svh"

module tb_vector_alu;

    import vec_pkg::*;

    localparam int N_FIXED     = 8;
    localparam int N_ROWS      = 20;
    localparam int MAX_DELAY   = 3;
    localparam int MAX_STALL   = 5;
    localparam int LATENCY     = `VEC_LEN / `VEC_TILING + 2;
    localparam int WAIT_MAX    = `VEC_LEN + MAX_DELAY + 10;
    localparam int CELL_MAX    = 2 ** (`VEC_CELL_W - 1) - 1;
    localparam int CELL_MIN    = -(2 ** (`VEC_CELL_W - 1));
    localparam int WATCHDOG_NS =
        (N_ROWS * (`VEC_LEN + MAX_DELAY + MAX_STALL + 10) + 10) * 100;

    logic        clk = 1'b0;
    logic        rst;
    vec_t        a;
    op_t         a_op;
    logic        a_valid;
    logic        a_ready;
    vec_t        b;
    logic        b_valid;
    logic        b_ready;
    vec_t        result;
    logic        result_valid;
    logic        result_ready;
    logic        error;

    op_t         tab_op    [N_ROWS];
    vec_t        tab_a     [N_ROWS];
    vec_t        tab_b     [N_ROWS];
    int          tab_delay [N_ROWS];
    int          tab_stall [N_ROWS];
    vec_t        tab_res   [N_ROWS];
    logic        tab_err   [N_ROWS];

    int          cycle_count = 0;
    int          check_fails = 0;
    int          rows_run = 0;
    int          rows_failed = 0;
    logic        stuck = 1'b0;
    logic [31:0] lcg_state = 32'd98;

    vector_alu_top UUT (
        .clk          (clk),
        .rst          (rst),
        .a            (a),
        .a_op         (a_op),
        .a_valid      (a_valid),
        .a_ready      (a_ready),
        .b            (b),
        .b_valid      (b_valid),
        .b_ready      (b_ready),
        .result       (result),
        .result_valid (result_valid),
        .result_ready (result_ready),
        .error        (error)
    );

    always #50 clk = ~clk;

    // posedges so far, read only on falling edges
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    task automatic check_vec(input vec_t got, input vec_t exp, input string what);
        if (got !== exp) begin
            check_fails++;
            $display("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            check_fails++;
            $display("FAILED at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_cycles(input int got, input int exp, input string what);
        if (got != exp) begin
            check_fails++;
            $display("FAILED at %0t: %s is %0d cycles, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic set_row(input int idx, input op_t op, input vec_t va, input vec_t vb,
                           input int delay, input int stall, input vec_t res, input logic err);
        tab_op[idx]    = op;
        tab_a[idx]     = va;
        tab_b[idx]     = vb;
        tab_delay[idx] = delay;
        tab_stall[idx] = stall;
        tab_res[idx]   = res;
        tab_err[idx]   = err;
    endtask

    // wrapping signed lanes, error when any true sum leaves the cell range
    task automatic fill_expected(input int idx);
        cell_t ca;
        cell_t cb;
        int    s;
        tab_res[idx] = '0;
        tab_err[idx] = 1'b0;
        for (int i = 0; i < `VEC_LEN; i++) begin
            ca = tab_a[idx][i*`VEC_CELL_W +: `VEC_CELL_W];
            cb = tab_b[idx][i*`VEC_CELL_W +: `VEC_CELL_W];
            s = tab_op[idx] ? int'(ca) - int'(cb) : int'(ca) + int'(cb);
            tab_res[idx][i*`VEC_CELL_W +: `VEC_CELL_W] = s[`VEC_CELL_W-1:0];
            if (s > CELL_MAX || s < CELL_MIN) begin
                tab_err[idx] = 1'b1;
            end
        end
    endtask

    task automatic build_table();
        logic [31:0] rnd;
        // cell 4 is the leftmost byte
        set_row(0, 1'b0, 40'h05_04_03_02_01, 40'h32_28_1E_14_0A, 0, 0, 40'h37_2C_21_16_0B, 1'b0);
        set_row(1, 1'b0, 40'h3C_FF_00_CE_64, 40'hC4_81_00_B2_1B, 3, 1, 40'h00_80_00_80_7F, 1'b0);
        set_row(2, 1'b1, 40'h00_9C_64_FB_05, 40'h81_1C_E5_07_03, -2, 0, 40'h7F_80_7F_F4_02, 1'b0);
        set_row(3, 1'b0, 40'h00_00_00_80_7F, 40'h00_00_00_FF_01, 2, 3, 40'h00_00_00_7F_80, 1'b1);
        set_row(4, 1'b0, 40'h01_01_01_01_01, 40'h00_00_00_00_00, 0, 0, 40'h01_01_01_01_01, 1'b0);
        set_row(5, 1'b1, 40'h00_00_80_00_00, 40'h00_00_01_00_00, 1, 2, 40'h00_00_7F_00_00, 1'b1);
        set_row(6, 1'b1, 40'h00_00_00_00_7F, 40'h00_00_00_00_FF, -1, 0, 40'h00_00_00_00_80, 1'b1);
        set_row(7, 1'b1, 40'h0A_0A_0A_0A_0A, 40'h03_03_03_03_03, -3, 5, 40'h07_07_07_07_07, 1'b0);
        for (int k = N_FIXED; k < N_ROWS; k++) begin
            rnd = lcg_next();
            tab_op[k]    = rnd[24];
            tab_delay[k] = int'(rnd[18:16] % 3'd7) - MAX_DELAY;
            tab_stall[k] = int'(rnd[22:20] % 3'd6);
            for (int c = 0; c < `VEC_LEN; c++) begin
                rnd = lcg_next();
                tab_a[k][c*`VEC_CELL_W +: `VEC_CELL_W] = rnd[16 +: `VEC_CELL_W];
                rnd = lcg_next();
                tab_b[k][c*`VEC_CELL_W +: `VEC_CELL_W] = rnd[16 +: `VEC_CELL_W];
            end
            fill_expected(k);
        end
    endtask

    // called on a falling edge, returns on a falling edge
    task automatic run_row(input int idx);
        int   a_at;
        int   b_at;
        int   cyc;
        int   acc_a;
        int   acc_b;
        int   fails_before;
        vec_t seen;
        fails_before = check_fails;
        a_at  = (tab_delay[idx] < 0) ? -tab_delay[idx] : 0;
        b_at  = (tab_delay[idx] > 0) ? tab_delay[idx] : 0;
        acc_a = -1;
        acc_b = -1;
        cyc   = 0;
        while ((acc_a < 0 || acc_b < 0) && cyc <= WAIT_MAX) begin
            if (acc_a < 0 && cyc >= a_at) begin
                a       = tab_a[idx];
                a_op    = tab_op[idx];
                a_valid = 1'b1;
            end
            if (acc_b < 0 && cyc >= b_at) begin
                b       = tab_b[idx];
                b_valid = 1'b1;
            end
            // transfer happens on the coming rising edge
            if (acc_a < 0 && a_valid && a_ready) begin
                acc_a = cycle_count + 1;
            end
            if (acc_b < 0 && b_valid && b_ready) begin
                acc_b = cycle_count + 1;
            end
            @(negedge clk);
            if (acc_a >= 0) begin
                a_valid = 1'b0;
            end
            if (acc_b >= 0) begin
                b_valid = 1'b0;
            end
            cyc++;
        end
        if (acc_a < 0 || acc_b < 0) begin
            $display("row %0d: operands were never accepted by the DUT", idx);
            a_valid = 1'b0;
            b_valid = 1'b0;
            stuck   = 1'b1;
            rows_failed++;
            return;
        end
        cyc = 0;
        while (!result_valid && cyc <= WAIT_MAX) begin
            @(negedge clk);
            cyc++;
        end
        if (!result_valid) begin
            $display("row %0d: the DUT never presented a result", idx);
            stuck = 1'b1;
            rows_failed++;
            return;
        end
        check_cycles(cycle_count - ((acc_a > acc_b) ? acc_a : acc_b), LATENCY, "latency");
        check_vec(result, tab_res[idx], "result");
        check_flag(error, tab_err[idx], "error");
        seen = result;
        repeat (tab_stall[idx]) begin
            @(negedge clk);
            check_flag(result_valid, 1'b1, "result_valid under stall");
            check_vec(result, seen, "result under stall");
            check_flag(error, tab_err[idx], "error under stall");
            check_flag(a_ready, 1'b0, "a_ready under stall");
            check_flag(b_ready, 1'b0, "b_ready under stall");
        end
        result_ready = 1'b1;
        @(negedge clk);
        result_ready = 1'b0;
        check_flag(result_valid, 1'b0, "result_valid after accept");
        check_flag(a_ready, 1'b1, "a_ready after accept");
        check_flag(b_ready, 1'b1, "b_ready after accept");
        if (check_fails != fails_before) begin
            rows_failed++;
        end
        $display("row %0d %s delay %0d stall %0d error %b: %s", idx,
                 tab_op[idx] ? "sub" : "add", tab_delay[idx], tab_stall[idx], tab_err[idx],
                 (check_fails == fails_before) ? "ok" : "mismatch");
    endtask

    initial begin
        rst          = 1'b1;
        a            = '0;
        a_op         = '0;
        a_valid      = 1'b0;
        b            = '0;
        b_valid      = 1'b0;
        result_ready = 1'b0;
        build_table();
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_flag(a_ready, 1'b1, "a_ready after reset");
        check_flag(b_ready, 1'b1, "b_ready after reset");
        check_flag(result_valid, 1'b0, "result_valid after reset");
        check_flag(error, 1'b0, "error after reset");
        $display("reset state: %s", (check_fails == 0) ? "ok" : "mismatch");
        for (int i = 0; i < N_ROWS && !stuck; i++) begin
            run_row(i);
            rows_run++;
        end
        $display("rows run %0d of %0d, rows failed %0d, checks failed %0d",
                 rows_run, N_ROWS, rows_failed, check_fails);
        if (check_fails == 0 && rows_failed == 0 && rows_run == N_ROWS) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+.
vec_pkg.sv
operand_decode.sv
lane_execute.sv
result_collect.sv
vector_alu_top.sv
tb_vector_alu.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_vector_alu -f filelist.f

if ./obj_dir/Vtb_vector_alu | tee /dev/stderr | grep "ALL TESTS PASSED" > /dev/null; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
